// File: Bender.yml
package:
  name: vc_output_port

sources:
  - files:
      - rtl/vc_port_pkg.sv
      - rtl/port_grant_select.sv
      - rtl/output_priority_mux.sv
      - rtl/phit_serializer.sv
      - rtl/vc_output_port.sv
  - target: simulation
    files:
      - verif/tb_vc_output_port.sv

// File: rtl/output_priority_mux.sv
`timescale 1ns/1ps
`default_nettype none

// fixed priority choice among the five port picks
// order is north, east, west, south, local
// also tells the vc allocator when a downstream vc can be released
module output_priority_mux
  import vc_port_pkg::*;
(
  input  wire port_pick_t picks [NUM_PORTS],  // one pick per input port
  input  wire vc_id_t     vc_selected,        // downstream vc of the granted flit
  output port_pick_t      win,                // pick that goes to the link
  output logic            free_vc,            // release request to the vc allocator
  output vc_id_t          vc_to_release       // vc named by free_vc
);

  logic win_is_last;  // winner closes its message

  //////////////////////////////
  // priority select
  //////////////////////////////

  always_comb
  begin
    if (picks[PORT_N].valid)
    begin
      win = picks[PORT_N];
    end
    else if (picks[PORT_E].valid)
    begin
      win = picks[PORT_E];
    end
    else if (picks[PORT_W].valid)
    begin
      win = picks[PORT_W];
    end
    else if (picks[PORT_S].valid)
    begin
      win = picks[PORT_S];
    end
    else
    begin
      win = picks[PORT_L];  // local last, its valid may be low
    end
  end

  //////////////////////////////
  // vc release
  //////////////////////////////

  // tail or header_tail leaving means the message is done
  always_comb
  begin
    case (win.flit_type)
      FLIT_TAIL,
      FLIT_HEADER_TAIL: win_is_last = 1'b1;
      default:          win_is_last = 1'b0;
    endcase
  end

  assign free_vc = win.valid & win_is_last;  // only in the grant cycle

  // the vc being released is the one picked downstream for this flit
  assign vc_to_release = vc_selected;

endmodule

`default_nettype wire

// File: rtl/phit_serializer.sv
`timescale 1ns/1ps
`default_nettype none

// link register and phit sequencer
// a valid win is stored and sent as NUM_PHITS phits, lowest first
// a new win always restarts the count, even mid flit
module phit_serializer
  import vc_port_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   rst_p,          // sync, active high
  input  wire port_pick_t win,        // flit chosen by the mux this cycle
  input  wire vc_id_t vc_selected,    // downstream vc from the allocator
  output logic        valid,          // phit on the link is meaningful
  output logic [PHIT_SIZE-1:0] phit,  // current link word
  output flit_type_e  flit_type_out,  // type of the flit being sent
  output logic        broadcast_out,
  output vc_id_t      vc_out,         // registered vc_selected
  output logic        go_phit         // allocator may grant again
);

  flit_word_u            flit_q;     // stored flit, payload only
  logic [PHIT_CNT_W-1:0] phit_cnt;   // index of the phit on the link
  logic                  last_phit;  // counter sits at the final phit

  assign last_phit = (phit_cnt == PHIT_CNT_W'(NUM_PHITS - 1));

  //////////////////////////////
  // flow control and link data
  //////////////////////////////

  // high only once the last phit is out and nothing new is coming
  assign go_phit = last_phit & ~win.valid;

  assign phit = flit_q.phits[phit_cnt];  // counter walks the union

  //////////////////////////////
  // payload register
  //////////////////////////////

  always_ff @(posedge clk)
  begin
    if (win.valid)
    begin
      flit_q <= win.flit;  // replaces any flit still in flight
    end
  end

  //////////////////////////////
  // control state
  //////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst_p)
    begin
      valid         <= 1'b0;
      phit_cnt      <= PHIT_CNT_W'(NUM_PHITS - 1);  // idle looks like a finished flit
      flit_type_out <= FLIT_HEADER;
      broadcast_out <= 1'b0;
      vc_out        <= '0;
    end
    else
    begin
      vc_out <= vc_selected;  // follows the allocator every cycle

      if (win.valid)
      begin
        // new flit, phit 0 shows next cycle
        valid         <= 1'b1;
        phit_cnt      <= '0;
        flit_type_out <= win.flit_type;
        broadcast_out <= win.broadcast;
      end
      else if (!last_phit)
      begin
        valid    <= 1'b1;
        phit_cnt <= phit_cnt + PHIT_CNT_W'(1);  // next phit
      end
      else
      begin
        valid <= 1'b0;  // flit done, counter parks at the last phit
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/port_grant_select.sv
`timescale 1ns/1ps
`default_nettype none

// picks the granted vc out of one input port
// purely combinational, no latency
module port_grant_select
  import vc_port_pkg::*;
(
  input  wire logic [NUM_VNXVC-1:0] grant,  // one-hot vc grant from the allocator
  input  wire port_in_t             port,   // flits, types and broadcast bits of the port
  output port_pick_t                pick    // selected entry
);

  vc_id_t vc_idx;  // encoded grant

  //////////////////////////////
  // one-hot to index
  //////////////////////////////

  // lowest set bit wins so a bad grant still indexes a real vc
  always_comb
  begin
    vc_idx = '0;
    for (int i = NUM_VNXVC - 1; i >= 0; i--)
    begin
      if (grant[i])
      begin
        vc_idx = vc_id_t'(i);
      end
    end
  end

  //////////////////////////////
  // entry select
  //////////////////////////////

  always_comb
  begin
    pick.valid     = |grant;                   // any vc granted at this port
    pick.flit      = port.flits[vc_idx];       // payload of the granted vc
    pick.flit_type = port.types[vc_idx];
    pick.broadcast = port.broadcast[vc_idx];   // single bit per vc
  end

endmodule

`default_nettype wire

// File: rtl/vc_output_port.sv
`timescale 1ns/1ps
`default_nettype none

// output port of a vc/vn switch
// stage 1 selects the granted flit at every input port and picks one by priority
// stage 2 registers it and sends it over the narrow link as phits
module vc_output_port
  import vc_port_pkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 rst_p,
  input  wire port_in_t             ports  [NUM_PORTS],  // offers from the input buffers
  input  wire logic [NUM_VNXVC-1:0] grants [NUM_PORTS],  // one-hot vc grant per port
  input  wire vc_id_t               vc_selected,         // downstream vc for the grant
  // to the vc allocator
  output logic                      free_vc,
  output vc_id_t                    vc_to_release,
  // link side
  output logic                      valid,
  output logic [PHIT_SIZE-1:0]      phit,
  output flit_type_e                flit_type_out,
  output logic                      broadcast_out,
  output vc_id_t                    vc_out,
  // to the switch allocator
  output logic                      go_phit
);

  port_pick_t picks [NUM_PORTS];  // per-port select results
  port_pick_t win;                // priority winner

  //////////////////////////////
  // select stage
  //////////////////////////////

  for (genvar p = 0; p < NUM_PORTS; p++)
  begin : g_sel
    port_grant_select u_sel (
      .grant (grants[p]),
      .port  (ports[p]),
      .pick  (picks[p])
    );
  end

  output_priority_mux u_mux (
    .picks         (picks),
    .vc_selected   (vc_selected),
    .win           (win),
    .free_vc       (free_vc),
    .vc_to_release (vc_to_release)
  );

  //////////////////////////////
  // link stage
  //////////////////////////////

  phit_serializer u_ser (
    .clk           (clk),
    .rst_p         (rst_p),
    .win           (win),
    .vc_selected   (vc_selected),
    .valid         (valid),
    .phit          (phit),
    .flit_type_out (flit_type_out),
    .broadcast_out (broadcast_out),
    .vc_out        (vc_out),
    .go_phit       (go_phit)
  );

endmodule

`default_nettype wire

// File: rtl/vc_port_pkg.sv
`default_nettype none

package vc_port_pkg;

  //////////////////////////////
  // flit and link sizes
  //////////////////////////////

  localparam int FLIT_SIZE  = 64;                      // bits in one flit
  localparam int PHIT_SIZE  = 16;                      // bits moved per link cycle
  localparam int NUM_PHITS  = FLIT_SIZE / PHIT_SIZE;   // phits per flit
  localparam int PHIT_CNT_W = $clog2(NUM_PHITS);       // phit counter width

  //////////////////////////////
  // virtual channels and ports
  //////////////////////////////

  localparam int NUM_VC    = 2;                 // vcs in each vn
  localparam int NUM_VN    = 3;                 // virtual networks
  localparam int NUM_VNXVC = NUM_VC * NUM_VN;   // vcs seen at one port
  localparam int VC_ID_W   = $clog2(NUM_VNXVC); // vc id width
  localparam int NUM_PORTS = 5;                 // input ports of the switch

  // index of each input port in grant and port arrays
  // lower index wins in the output mux
  localparam int PORT_N = 0;
  localparam int PORT_E = 1;
  localparam int PORT_W = 2;
  localparam int PORT_S = 3;
  localparam int PORT_L = 4;

  //////////////////////////////
  // types
  //////////////////////////////

  // flit kinds carried next to each flit
  typedef enum logic [1:0] {
    FLIT_HEADER      = 2'd0,
    FLIT_BODY        = 2'd1,
    FLIT_TAIL        = 2'd2,
    FLIT_HEADER_TAIL = 2'd3    // single-flit message
  } flit_type_e;

  typedef logic [VC_ID_W-1:0] vc_id_t;  // vc identifier, vn is implied by range

  // one flit word, either whole or as link phits
  // phits[0] sits in the lowest bits and goes out first
  typedef union packed {
    logic [FLIT_SIZE-1:0]                word;
    logic [NUM_PHITS-1:0][PHIT_SIZE-1:0] phits;
  } flit_word_u;

  // what one input port offers, one entry per vc
  typedef struct packed {
    flit_word_u [NUM_VNXVC-1:0] flits;      // candidate flits
    flit_type_e [NUM_VNXVC-1:0] types;      // type per flit
    logic       [NUM_VNXVC-1:0] broadcast;  // one broadcast bit per vc
  } port_in_t;

  // result of the select stage for one port
  typedef struct packed {
    logic       valid;       // some vc of this port was granted
    flit_word_u flit;
    flit_type_e flit_type;
    logic       broadcast;
  } port_pick_t;

endpackage

`default_nettype wire

// File: sim.f
rtl/vc_port_pkg.sv
rtl/port_grant_select.sv
rtl/output_priority_mux.sv
rtl/phit_serializer.sv
rtl/vc_output_port.sv
verif/tb_vc_output_port.sv

// File: verif/tb_vc_output_port.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vc_output_port
  import vc_port_pkg::*;
();

  localparam int    VALID_TIMEOUT = 8;                               // cycles to wait for phit 0
  localparam string TEST_FILE     = "verif/vc_output_port_tests.txt";

  logic                 clk = 1'b0;
  logic                 rst_p;
  port_in_t             ports  [NUM_PORTS];  // offers seen by the dut
  logic [NUM_VNXVC-1:0] grants [NUM_PORTS];
  vc_id_t               vc_selected;

  logic                 free_vc;
  vc_id_t               vc_to_release;
  logic                 valid;
  logic [PHIT_SIZE-1:0] phit;
  flit_type_e           flit_type_out;
  logic                 broadcast_out;
  vc_id_t               vc_out;
  logic                 go_phit;

  // current test line
  string                test_name;
  logic [NUM_VNXVC-1:0] t_grant [NUM_PORTS];
  int                   t_vc;
  int                   t_type  [NUM_PORTS];  // type code of the granted vc at each port
  int                   t_cut;                // phits checked before the next grant

  // testbench copy of the port contents
  logic [FLIT_SIZE-1:0] payload [NUM_PORTS][NUM_VNXVC];
  logic                 bcast   [NUM_PORTS][NUM_VNXVC];
  integer               seed;
  int                   num_tests;

  always #20 clk = ~clk;  // 40 ns period

  vc_output_port uut (
    .clk           (clk),
    .rst_p         (rst_p),
    .ports         (ports),
    .grants        (grants),
    .vc_selected   (vc_selected),
    .free_vc       (free_vc),
    .vc_to_release (vc_to_release),
    .valid         (valid),
    .phit          (phit),
    .flit_type_out (flit_type_out),
    .broadcast_out (broadcast_out),
    .vc_out        (vc_out),
    .go_phit       (go_phit)
  );

  //////////////////////////////
  // error handling and checks
  //////////////////////////////

  task stop_run(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act)
    else stop_run($sformatf("Fail %s %s: expected %0h, actual %0h", test_name, what, exp, act));
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////

  // rank 0 is the strongest input
  function int port_at_rank(input int r);
    case (r)
      0:       port_at_rank = PORT_N;
      1:       port_at_rank = PORT_E;
      2:       port_at_rank = PORT_W;
      3:       port_at_rank = PORT_S;
      default: port_at_rank = PORT_L;
    endcase
  endfunction

  function int winning_port();
    int p;
    winning_port = -1;
    for (int r = NUM_PORTS - 1; r >= 0; r--)  // walk up so the strongest rank is kept
    begin
      p = port_at_rank(r);
      if (t_grant[p] != '0)
        winning_port = p;
    end
  endfunction

  function int onehot_index(input logic [NUM_VNXVC-1:0] g);
    onehot_index = 0;
    for (int i = NUM_VNXVC - 1; i >= 0; i--)
    begin
      if (g[i])
        onehot_index = i;
    end
  endfunction

  //////////////////////////////
  // one test
  //////////////////////////////

  task run_test();
    int                   wp;        // expected winning port
    int                   wv;        // expected vc at that port
    int                   waited;
    logic [31:0]          rnd;
    logic [FLIT_SIZE-1:0] exp_flit;
    logic                 exp_last;  // tail or header_tail

    @(posedge clk);
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      for (int v = 0; v < NUM_VNXVC; v++)
      begin
        payload[p][v] = {$random(seed), $random(seed)};  // fresh payload each test
        rnd           = $random(seed);
        bcast[p][v]   = rnd[0];
        ports[p].flits[v]     <= payload[p][v];
        if (t_grant[p][v])
          ports[p].types[v]   <= flit_type_e'(t_type[p][1:0]);
        else
          ports[p].types[v]   <= flit_type_e'(~t_type[p][1:0]);  // other vcs differ in type
        ports[p].broadcast[v] <= bcast[p][v];
      end
      grants[p] <= t_grant[p];
    end
    vc_selected <= vc_id_t'(t_vc);

    wp       = winning_port();
    wv       = onehot_index(t_grant[wp]);
    exp_flit = payload[wp][wv];
    exp_last = (t_type[wp] == int'(FLIT_TAIL)) || (t_type[wp] == int'(FLIT_HEADER_TAIL));

    // release is combinational and shows in the grant cycle
    @(negedge clk);
    check_value("free_vc", exp_last, free_vc);
    check_value("vc_to_release", t_vc, vc_to_release);
    check_value("go_phit in grant cycle", 0, go_phit);

    @(posedge clk);
    for (int p = 0; p < NUM_PORTS; p++)
      grants[p] <= '0;  // one-cycle strobe

    waited = 0;
    @(negedge clk);
    while (!valid && waited < VALID_TIMEOUT)
    begin
      waited++;
      @(negedge clk);
    end
    assert (valid)
    else stop_run($sformatf("valid never rose after the grant in test %s", test_name));
    check_value("cycles to phit 0", 0, waited);  // phit 0 belongs in the cycle after the grant

    for (int k = 0; k < t_cut; k++)
    begin
      if (k > 0)
        @(negedge clk);
      check_value($sformatf("valid at phit %0d", k), 1, valid);
      check_value($sformatf("phit %0d", k), exp_flit[k*PHIT_SIZE +: PHIT_SIZE], phit);
      check_value("flit_type_out", t_type[wp], flit_type_out);
      check_value("broadcast_out", bcast[wp][wv], broadcast_out);
      check_value("vc_out", t_vc, vc_out);
      check_value($sformatf("go_phit at phit %0d", k), (k == NUM_PHITS - 1), go_phit);
    end

    if (t_cut >= NUM_PHITS)
    begin
      @(negedge clk);
      check_value("valid after last phit", 0, valid);
      check_value("go_phit after last phit", 1, go_phit);
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial
  begin
    int    fd;
    int    n;
    string line;

    seed      = 32'h14f3a4dd;
    num_tests = 0;
    test_name = "reset";
    rst_p       <= 1'b1;
    vc_selected <= '0;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      ports[p]  <= '0;
      grants[p] <= '0;
    end

    repeat (10) @(posedge clk);
    rst_p <= 1'b0;

    @(negedge clk);
    check_value("valid", 0, valid);
    check_value("go_phit", 1, go_phit);
    check_value("free_vc", 0, free_vc);
    check_value("flit_type_out", FLIT_HEADER, flit_type_out);
    check_value("broadcast_out", 0, broadcast_out);
    check_value("vc_out", 0, vc_out);

    fd = $fopen(TEST_FILE, "r");
    if (fd == 0)
      stop_run($sformatf("could not open the test file %s", TEST_FILE));

    while (!$feof(fd))
    begin
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line[0] != "#")  // skip blanks and comments
      begin
        n = $sscanf(line, "%s %b %b %b %b %b %d %d %d %d %d %d %d", test_name,
                    t_grant[0], t_grant[1], t_grant[2], t_grant[3], t_grant[4], t_vc,
                    t_type[0], t_type[1], t_type[2], t_type[3], t_type[4], t_cut);
        assert (n == 13)
        else stop_run($sformatf("malformed line in the test file: %s", line));
        run_test();
        num_tests++;
      end
    end
    $fclose(fd);

    repeat (2) @(posedge clk);
    if (num_tests == 0)
    begin
      stop_run("no tests were read from the test file");
    end
    else
    begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verif/vc_output_port_tests.txt
# name grant_n grant_e grant_w grant_s grant_l vc_selected type_n type_e type_w type_s type_l phits
# grants one-hot with vc 0 on the right; types 0 header 1 body 2 tail 3 header_tail; phits 4 = full flit
single_n_vc0        000001 000000 000000 000000 000000 0 0 1 1 1 1 4
single_e_vc3        000000 001000 000000 000000 000000 3 1 1 1 1 1 4
single_w_vc5        000000 000000 100000 000000 000000 5 1 1 3 1 1 4
single_s_vc1        000000 000000 000000 000010 000000 1 1 1 1 2 1 4
single_l_vc4        000000 000000 000000 000000 010000 4 0 0 0 0 0 4
single_l_vc2        000000 000000 000000 000000 000100 2 0 0 0 0 3 4
prio_n_over_e       000100 010000 000000 000000 000000 2 2 1 1 1 1 4
prio_e_over_w       000000 000001 100000 000000 000000 1 0 1 3 0 0 4
prio_w_over_s       000000 000000 000010 000100 000000 5 1 1 2 3 0 4
prio_s_over_l       000000 000000 000000 100000 000001 0 1 1 1 0 3 4
prio_all_ports      001000 000100 000010 000001 100000 3 3 2 1 0 1 4
prio_e_w_l          000000 100000 000001 000000 001000 4 0 2 3 3 3 4
prio_w_l            000000 000000 010000 000000 000010 1 3 3 0 3 3 4
prio_n_l            000010 000000 000000 000000 000001 2 2 0 0 0 1 4
release_body        010000 000000 000000 000000 000000 4 1 2 2 2 2 4
release_header      000000 000010 000000 000000 000000 0 2 0 3 3 3 4
release_tail        000000 000000 000000 001000 000000 3 0 0 0 2 0 4
release_header_tail 000000 000000 000000 000000 100000 5 0 0 0 0 3 4
release_tail_w      000000 000000 000100 000000 000000 1 0 0 2 0 0 4
cut_after_phit0     000001 000000 000000 000000 000000 0 0 1 1 1 1 1
restart_cut_phit1   000000 000100 000000 000000 000000 2 1 1 1 1 1 2
restart_cut_phit2   000000 000000 010000 000000 000000 4 1 1 2 1 1 3
restart_full        000000 000000 000000 000001 000000 1 1 1 1 3 1 4
cut_prio_a          000000 001000 000000 000000 000010 3 0 3 0 0 0 2
cut_prio_b          100000 000000 000000 000001 000000 5 2 0 0 1 0 4
back_to_back_a      000000 000000 000000 000000 000001 3 0 0 0 0 2 4
back_to_back_b      100000 000000 000000 000000 000000 5 3 0 0 0 0 4
final_local_ht      000000 000000 000000 000000 001000 0 1 1 1 1 3 4
